// File: logic/ads_pkg.sv
package ads_pkg;

	// ==============================
	// widths
	// ==============================
	typedef logic [7:0]  byte_t;      // one spi byte
	typedef logic [4:0]  reg_addr_t;  // adc register address
	typedef logic [71:0] frame_t;     // status | ch1 | ch2, 24 bits each

	// host command codes
	typedef enum logic [1:0] {
		CTRL_WREG   = 2'd0,  // write one register
		CTRL_RREG   = 2'd1,  // read one register
		CTRL_RDATAC = 2'd2,  // enter continuous read
		CTRL_SDATAC = 2'd3   // leave continuous read
	} ctrl_e;

	// host request, captured by the sequencer on accept
	typedef struct packed {
		ctrl_e     code;
		reg_addr_t addr;  // only for wreg/rreg
		byte_t     data;  // only for wreg
	} host_cmd_t;

	// one byte towards the spi engine
	typedef struct packed {
		byte_t tx_byte;
		logic  valid;
	} spi_req_t;

	// engine status and received byte
	typedef struct packed {
		logic  ready;
		byte_t rx_byte;
		logic  rx_valid;  // one cycle, 8th bit sampled
	} spi_rsp_t;

	// ==============================
	// opcodes
	// ==============================
	localparam logic [2:0] OP_RREG_PREFIX = 3'b001;  // 001a aaaa
	localparam logic [2:0] OP_WREG_PREFIX = 3'b010;  // 010a aaaa
	localparam byte_t      OP_COUNT_ONE   = 8'h00;   // count minus one
	localparam byte_t      CMD_RDATAC     = 8'h10;
	localparam byte_t      CMD_SDATAC     = 8'h11;
	localparam int         FRAME_BYTES    = 9;       // 72 bits per frame

endpackage

// File: logic/spi_byte_master.sv
`timescale 1ns/1ps

// mode 1 master, cpol 0 / cpha 1
// mosi changes on rising sclk, miso sampled on falling sclk, msb first
module spi_byte_master #(
	parameter int CLKS_PER_HALF_BIT = 2  // system clocks per sclk half period
) (
	input  logic              i_CLK,
	input  logic              i_RSTN,
	input  ads_pkg::spi_req_t i_req,
	input  logic              i_spi_miso,
	output ads_pkg::spi_rsp_t o_rsp,
	output logic              o_spi_clk,
	output logic              o_spi_mosi
);

	localparam int HALF_W = $clog2(CLKS_PER_HALF_BIT + 1);
	localparam int EDGES  = 16;  // 8 bits, two edges each

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SHIFT,
		ST_DONE   // rx_valid cycle, already takes the next byte
	} state_e;

	state_e            r_state;
	logic [HALF_W-1:0] r_half_cnt;  // clocks inside one half bit
	logic [4:0]        r_edge_cnt;  // sclk edges still to go
	logic              r_sclk;
	logic              r_mosi;
	ads_pkg::byte_t    r_tx_shift;
	ads_pkg::byte_t    r_rx_shift;
	logic              w_ready;
	logic              w_accept;
	logic              w_toggle;

	assign w_ready  = (r_state != ST_SHIFT);
	assign w_accept = i_req.valid & w_ready;
	// end of a half bit, sclk flips here
	assign w_toggle = (r_state == ST_SHIFT) &&
		(r_half_cnt == HALF_W'(CLKS_PER_HALF_BIT - 1));

	// ==============================
	// control and sclk
	// ==============================
	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_state    <= ST_IDLE;
			r_half_cnt <= '0;
			r_edge_cnt <= '0;
			r_sclk     <= 1'b0;  // cpol 0
			r_mosi     <= 1'b0;
		end else begin
			case (r_state)
				ST_SHIFT: begin
					if (w_toggle) begin
						r_half_cnt <= '0;
						r_sclk     <= ~r_sclk;
						r_edge_cnt <= r_edge_cnt - 5'd1;
						if (!r_sclk) begin
							r_mosi <= r_tx_shift[7];  // leading edge drives
						end
						if (r_edge_cnt == 5'd1) begin
							r_state <= ST_DONE;  // last falling edge
						end
					end else begin
						r_half_cnt <= r_half_cnt + 1'b1;
					end
				end
				default: begin
					// idle and done both accept
					if (w_accept) begin
						r_state    <= ST_SHIFT;
						r_half_cnt <= '0;
						r_edge_cnt <= 5'(EDGES);
					end else begin
						r_state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	// ==============================
	// data path
	// ==============================
	always_ff @(posedge i_CLK) begin
		if (w_accept) begin
			r_tx_shift <= i_req.tx_byte;
		end else if (w_toggle) begin
			if (!r_sclk) begin
				r_tx_shift <= {r_tx_shift[6:0], 1'b0};  // next bit up
			end else begin
				r_rx_shift <= {r_rx_shift[6:0], i_spi_miso};  // trailing edge samples
			end
		end
	end

	assign o_rsp = '{
		ready:    w_ready,
		rx_byte:  r_rx_shift,
		rx_valid: (r_state == ST_DONE)
	};
	assign o_spi_clk  = r_sclk;
	assign o_spi_mosi = r_mosi;

endmodule

// File: logic/frame_reader.sv
`timescale 1ns/1ps

// drdy driven frame capture, owns the spi engine while streaming
module frame_reader (
	input  logic              i_CLK,
	input  logic              i_RSTN,
	input  logic              i_stream_en,
	input  logic              i_drdy_n,
	input  ads_pkg::spi_req_t i_req,   // from sequencer
	input  ads_pkg::spi_rsp_t i_rsp,   // from engine
	output ads_pkg::spi_req_t o_req,   // to engine
	output ads_pkg::spi_rsp_t o_rsp,   // to sequencer
	output logic              o_frame_busy,
	output ads_pkg::frame_t   o_frame,
	output logic              o_frame_valid
);

	localparam int         FW        = $bits(ads_pkg::frame_t);
	localparam logic [3:0] LAST_BYTE = 4'(ads_pkg::FRAME_BYTES - 1);

	logic              r_drdy_meta;
	logic              r_drdy_sync;
	logic              r_drdy_prev;
	logic              r_busy;       // frame in progress
	logic              r_in_flight;  // dummy byte on the wire
	logic [3:0]        r_byte_cnt;
	logic              r_frame_valid;
	ads_pkg::frame_t   r_frame;
	ads_pkg::spi_req_t w_own_req;
	logic              w_drdy_fall;
	logic              w_own;
	logic              w_rx;

	assign w_drdy_fall = r_drdy_prev & ~r_drdy_sync;
	assign w_own       = i_stream_en | r_busy;  // finish a frame even if stream_en drops
	assign w_rx        = i_rsp.rx_valid & r_in_flight;
	assign w_own_req   = '{tx_byte: '0, valid: r_busy & ~r_in_flight};

	// drdy sync, idles high
	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_drdy_meta <= 1'b1;
			r_drdy_sync <= 1'b1;
			r_drdy_prev <= 1'b1;
		end else begin
			r_drdy_meta <= i_drdy_n;
			r_drdy_sync <= r_drdy_meta;
			r_drdy_prev <= r_drdy_sync;
		end
	end

	// ==============================
	// nine dummy bytes per drdy
	// ==============================
	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_busy        <= 1'b0;
			r_in_flight   <= 1'b0;
			r_byte_cnt    <= '0;
			r_frame_valid <= 1'b0;
		end else begin
			r_frame_valid <= 1'b0;
			if (r_busy) begin
				if (w_own_req.valid && i_rsp.ready) begin
					r_in_flight <= 1'b1;
				end
				if (w_rx) begin
					r_in_flight <= 1'b0;
					r_byte_cnt  <= r_byte_cnt + 4'd1;
					if (r_byte_cnt == LAST_BYTE) begin
						r_busy        <= 1'b0;
						r_frame_valid <= 1'b1;  // cycle after the 9th byte
					end
				end
			end else if (i_stream_en && w_drdy_fall) begin
				r_busy     <= 1'b1;
				r_byte_cnt <= '0;
			end
		end
	end

	// first byte ends up in the top bits
	always_ff @(posedge i_CLK) begin
		if (w_rx) begin
			r_frame <= {r_frame[FW-9:0], i_rsp.rx_byte};
		end
	end

	// sequencer sees a busy engine while we own it
	assign o_req = w_own ? w_own_req : i_req;
	assign o_rsp = w_own ? '{ready: 1'b0, rx_byte: i_rsp.rx_byte, rx_valid: 1'b0} : i_rsp;

	assign o_frame_busy  = r_busy;
	assign o_frame       = r_frame;
	assign o_frame_valid = r_frame_valid;

endmodule

// File: logic/ads_sequencer.sv
`timescale 1ns/1ps

// power-up sequence plus host command FSM
module ads_sequencer #(
	parameter int POR_WAIT_CYCLES   = 25_000_000,  // power-on wait
	parameter int RESET_WAIT_CYCLES = 1758,        // reset low, then recovery
	parameter int CS_HOLD_CYCLES    = 392          // cs low after last sclk
) (
	input  logic               i_CLK,
	input  logic               i_RSTN,
	input  ads_pkg::host_cmd_t i_cmd,
	input  logic               i_cmd_valid,
	input  ads_pkg::spi_rsp_t  i_rsp,
	input  logic               i_frame_busy,
	input  logic               i_drdy_n,
	output logic               o_cmd_ready,
	output ads_pkg::spi_req_t  o_req,
	output logic               o_stream_en,
	output ads_pkg::byte_t     o_rreg_data,
	output logic               o_rreg_valid,
	output logic               o_init_done,
	output logic               o_streaming,
	output logic               o_spi_csn,
	output logic               o_ads_start,
	output logic               o_ads_resetn
);

	typedef enum logic [3:0] {
		ST_POR_WAIT,
		ST_RST_LOW,
		ST_RST_WAIT,
		ST_STANDBY,
		ST_SEND,      // valid up, waiting for engine ready
		ST_XFER,      // byte on the wire
		ST_HOLD,      // cs hold before release
		ST_STREAM,
		ST_SD_WAIT,   // keep out of the drdy window
		ST_SD_DRAIN   // stream_en low, let a late frame finish
	} state_e;

	state_e             r_state;
	logic [31:0]        r_wait;      // shared delay counter
	ads_pkg::host_cmd_t r_cmd;
	logic [1:0]         r_byte_idx;  // byte of the current command
	ads_pkg::byte_t     w_tx_byte;
	logic               w_last_byte;
	logic               w_accept;
	logic               w_por_done;
	logic               w_rst_done;
	logic               w_hold_done;

	assign o_cmd_ready = (r_state == ST_STANDBY) || (r_state == ST_STREAM);
	assign w_accept    = i_cmd_valid & o_cmd_ready;
	assign o_req       = '{tx_byte: w_tx_byte, valid: (r_state == ST_SEND)};

	assign w_por_done  = (r_wait == 32'(POR_WAIT_CYCLES - 1));
	assign w_rst_done  = (r_wait == 32'(RESET_WAIT_CYCLES - 1));
	assign w_hold_done = (r_wait == 32'(CS_HOLD_CYCLES - 1));

	// ==============================
	// byte sequence per command
	// ==============================
	always_comb begin
		w_tx_byte   = ads_pkg::CMD_SDATAC;
		w_last_byte = 1'b1;
		case (r_cmd.code)
			ads_pkg::CTRL_WREG: begin
				w_last_byte = (r_byte_idx == 2'd2);
				case (r_byte_idx)
					2'd0:    w_tx_byte = {ads_pkg::OP_WREG_PREFIX, r_cmd.addr};
					2'd1:    w_tx_byte = ads_pkg::OP_COUNT_ONE;
					default: w_tx_byte = r_cmd.data;
				endcase
			end
			ads_pkg::CTRL_RREG: begin
				w_last_byte = (r_byte_idx == 2'd2);
				case (r_byte_idx)
					2'd0:    w_tx_byte = {ads_pkg::OP_RREG_PREFIX, r_cmd.addr};
					2'd1:    w_tx_byte = ads_pkg::OP_COUNT_ONE;
					default: w_tx_byte = 8'h00;  // dummy, clocks the data out
				endcase
			end
			ads_pkg::CTRL_RDATAC: w_tx_byte = ads_pkg::CMD_RDATAC;
			default:              w_tx_byte = ads_pkg::CMD_SDATAC;
		endcase
	end

	// ==============================
	// main FSM
	// ==============================
	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_state      <= ST_POR_WAIT;
			r_wait       <= '0;
			r_cmd        <= '0;
			r_byte_idx   <= '0;
			o_stream_en  <= 1'b0;
			o_rreg_valid <= 1'b0;
			o_init_done  <= 1'b0;
			o_streaming  <= 1'b0;
			o_spi_csn    <= 1'b1;
			o_ads_start  <= 1'b0;
			o_ads_resetn <= 1'b1;
		end else begin
			o_rreg_valid <= 1'b0;  // single cycle pulse
			case (r_state)
				ST_POR_WAIT: begin
					r_wait <= r_wait + 32'd1;
					if (w_por_done) begin
						r_wait       <= '0;
						o_ads_resetn <= 1'b0;  // reset pulse starts
						r_state      <= ST_RST_LOW;
					end
				end
				ST_RST_LOW: begin
					r_wait <= r_wait + 32'd1;
					if (w_rst_done) begin
						r_wait       <= '0;
						o_ads_resetn <= 1'b1;
						r_state      <= ST_RST_WAIT;
					end
				end
				ST_RST_WAIT: begin
					r_wait <= r_wait + 32'd1;
					if (w_rst_done) begin
						// chip wakes up in rdatac, stop it first
						r_wait     <= '0;
						r_cmd.code <= ads_pkg::CTRL_SDATAC;
						r_byte_idx <= '0;
						o_spi_csn  <= 1'b0;
						r_state    <= ST_SEND;
					end
				end
				ST_STANDBY: begin
					if (w_accept) begin
						r_cmd      <= i_cmd;
						r_byte_idx <= '0;
						o_spi_csn  <= 1'b0;
						r_state    <= ST_SEND;
					end
				end
				ST_SEND: begin
					if (i_rsp.ready) begin
						r_state <= ST_XFER;
					end
				end
				ST_XFER: begin
					if (i_rsp.rx_valid) begin
						r_wait <= '0;
						if (!w_last_byte) begin
							r_byte_idx <= r_byte_idx + 2'd1;
							r_state    <= ST_SEND;
						end else begin
							r_state <= ST_HOLD;
							case (r_cmd.code)
								ads_pkg::CTRL_RREG: o_rreg_valid <= 1'b1;
								ads_pkg::CTRL_RDATAC: begin
									o_ads_start <= 1'b1;  // cs stays low while streaming
									o_streaming <= 1'b1;
									o_stream_en <= 1'b1;
									r_state     <= ST_STREAM;
								end
								ads_pkg::CTRL_SDATAC: begin
									o_ads_start <= 1'b0;
									o_streaming <= 1'b0;
								end
								default: ;
							endcase
						end
					end
				end
				ST_HOLD: begin
					r_wait <= r_wait + 32'd1;
					if (w_hold_done) begin
						r_wait      <= '0;
						o_spi_csn   <= 1'b1;
						o_init_done <= 1'b1;  // first release ends power-up
						r_state     <= ST_STANDBY;
					end
				end
				ST_STREAM: begin
					// other codes are dropped here
					if (w_accept && (i_cmd.code == ads_pkg::CTRL_SDATAC)) begin
						r_cmd      <= i_cmd;
						r_byte_idx <= '0;
						r_state    <= ST_SD_WAIT;
					end
				end
				ST_SD_WAIT: begin
					if (!i_frame_busy && i_drdy_n) begin
						o_stream_en <= 1'b0;
						r_state     <= ST_SD_DRAIN;
					end
				end
				ST_SD_DRAIN: begin
					if (!i_frame_busy) begin
						r_state <= ST_SEND;
					end
				end
				default: r_state <= ST_POR_WAIT;
			endcase
		end
	end

	// rreg result, last byte of the exchange
	always_ff @(posedge i_CLK) begin
		if ((r_state == ST_XFER) && i_rsp.rx_valid && w_last_byte &&
			(r_cmd.code == ads_pkg::CTRL_RREG)) begin
			o_rreg_data <= i_rsp.rx_byte;
		end
	end

endmodule

// File: logic/ads1292_ctrl_top.sv
`timescale 1ns/1ps

// ads1292 controller, sequencer -> frame reader -> spi engine
module ads1292_ctrl_top #(
	parameter int CLKS_PER_HALF_BIT = 25,          // 1 MHz sclk at 50 MHz
	parameter int POR_WAIT_CYCLES   = 25_000_000,  // ~2^18 tclk at 512 kHz
	parameter int RESET_WAIT_CYCLES = 1758,        // 18 tclk
	parameter int CS_HOLD_CYCLES    = 392          // 4 tclk
) (
	input  logic               i_CLK,
	input  logic               i_RSTN,
	// host side
	input  ads_pkg::host_cmd_t i_cmd,
	input  logic               i_cmd_valid,
	output logic               o_cmd_ready,
	output ads_pkg::byte_t     o_rreg_data,
	output logic               o_rreg_valid,
	output ads_pkg::frame_t    o_frame,
	output logic               o_frame_valid,
	output logic               o_init_done,
	output logic               o_streaming,
	// adc side
	input  logic               i_spi_miso,
	input  logic               i_drdy_n,
	output logic               o_spi_clk,
	output logic               o_spi_mosi,
	output logic               o_spi_csn,
	output logic               o_ads_start,
	output logic               o_ads_resetn
);

	ads_pkg::spi_req_t seq_req;   // sequencer -> frame reader
	ads_pkg::spi_req_t eng_req;   // frame reader -> engine
	ads_pkg::spi_rsp_t eng_rsp;   // engine -> frame reader
	ads_pkg::spi_rsp_t seq_rsp;   // frame reader -> sequencer
	logic              stream_en;
	logic              frame_busy;

	ads_sequencer #(
		.POR_WAIT_CYCLES   (POR_WAIT_CYCLES),
		.RESET_WAIT_CYCLES (RESET_WAIT_CYCLES),
		.CS_HOLD_CYCLES    (CS_HOLD_CYCLES)
	) u_seq (
		.i_CLK        (i_CLK),
		.i_RSTN       (i_RSTN),
		.i_cmd        (i_cmd),
		.i_cmd_valid  (i_cmd_valid),
		.i_rsp        (seq_rsp),
		.i_frame_busy (frame_busy),
		.i_drdy_n     (i_drdy_n),
		.o_cmd_ready  (o_cmd_ready),
		.o_req        (seq_req),
		.o_stream_en  (stream_en),
		.o_rreg_data  (o_rreg_data),
		.o_rreg_valid (o_rreg_valid),
		.o_init_done  (o_init_done),
		.o_streaming  (o_streaming),
		.o_spi_csn    (o_spi_csn),
		.o_ads_start  (o_ads_start),
		.o_ads_resetn (o_ads_resetn)
	);

	frame_reader u_frame (
		.i_CLK         (i_CLK),
		.i_RSTN        (i_RSTN),
		.i_stream_en   (stream_en),
		.i_drdy_n      (i_drdy_n),
		.i_req         (seq_req),
		.i_rsp         (eng_rsp),
		.o_req         (eng_req),
		.o_rsp         (seq_rsp),
		.o_frame_busy  (frame_busy),
		.o_frame       (o_frame),
		.o_frame_valid (o_frame_valid)
	);

	spi_byte_master #(
		.CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT)
	) u_spi (
		.i_CLK      (i_CLK),
		.i_RSTN     (i_RSTN),
		.i_req      (eng_req),
		.i_spi_miso (i_spi_miso),
		.o_rsp      (eng_rsp),
		.o_spi_clk  (o_spi_clk),
		.o_spi_mosi (o_spi_mosi)
	);

endmodule

// File: test/ads1292_model.sv
`timescale 1ns/1ps

// ads1292 stand-in, spi slave oversampled on the system clock
module ads1292_model #(
	parameter int DRDY_PERIOD = 400  // system clocks between frames
) (
	input  logic i_CLK,
	input  logic i_RSTN,
	input  logic i_spi_clk,
	input  logic i_spi_mosi,
	input  logic i_spi_csn,
	input  logic i_ads_start,
	input  logic i_ads_resetn,
	output logic o_spi_miso,
	output logic o_drdy_n,
	output logic o_sdatac_seen
);

	ads_pkg::byte_t  r_regs [0:11];
	ads_pkg::byte_t  r_rx;          // bits of the current byte
	ads_pkg::byte_t  r_op;          // first byte of the command
	ads_pkg::byte_t  r_out;         // byte going out on miso
	ads_pkg::frame_t r_frame_sr;    // rest of the frame
	logic [3:0]      r_frame_left;
	logic [23:0]     r_frame_num;
	logic [15:0]     r_tick;
	logic [2:0]      r_bit_cnt;
	logic [1:0]      r_byte_idx;
	logic            r_sclk_d;
	logic            r_stream;      // continuous read mode
	ads_pkg::frame_t w_next_frame;
	ads_pkg::byte_t  w_byte;
	logic            w_rst_n;
	logic            w_fall;
	logic            w_byte_end;

	assign w_rst_n      = i_RSTN & i_ads_resetn;  // pin reset clears the chip too
	assign w_fall       = r_sclk_d & ~i_spi_clk & ~i_spi_csn;  // sclk fell, mosi still valid
	assign w_byte_end   = w_fall & (r_bit_cnt == 3'd7);
	assign w_byte       = {r_rx[6:0], i_spi_mosi};
	assign w_next_frame = {24'hC00000, r_frame_num, ~r_frame_num};
	// bit index moves after each falling edge, so the master sees a steady bit
	assign o_spi_miso   = i_spi_csn ? 1'b0 : r_out[3'd7 - r_bit_cnt];

	always_ff @(posedge i_CLK or negedge w_rst_n) begin
		if (!w_rst_n) begin
			for (int i = 0; i < 12; i++) begin
				r_regs[4'(i)] <= 8'hA0 + 8'(i);  // reset pattern
			end
			r_rx          <= '0;
			r_op          <= '0;
			r_out         <= '0;
			r_frame_sr    <= '0;
			r_frame_left  <= '0;
			r_frame_num   <= '0;
			r_tick        <= '0;
			r_bit_cnt     <= '0;
			r_byte_idx    <= '0;
			r_sclk_d      <= 1'b0;
			r_stream      <= 1'b0;
			o_drdy_n      <= 1'b1;
			o_sdatac_seen <= 1'b0;
		end else begin
			r_sclk_d <= i_spi_clk;
			if (i_spi_csn) begin
				r_bit_cnt  <= '0;  // deselect restarts the byte
				r_byte_idx <= '0;
			end else if (w_fall) begin
				r_rx      <= w_byte;
				r_bit_cnt <= r_bit_cnt + 3'd1;  // wraps after bit 7
			end

			// ==============================
			// byte decode
			// ==============================
			if (w_byte_end) begin
				r_out <= 8'h00;
				if (r_stream) begin
					if (w_byte == ads_pkg::CMD_SDATAC) begin
						r_stream      <= 1'b0;
						o_sdatac_seen <= 1'b1;
					end else if (r_frame_left != 4'd0) begin
						r_out        <= r_frame_sr[71:64];  // next frame byte
						r_frame_sr   <= r_frame_sr << 8;
						r_frame_left <= r_frame_left - 4'd1;
					end
				end else begin
					case (r_byte_idx)
						2'd0: begin
							r_op <= w_byte;
							if (w_byte == ads_pkg::CMD_RDATAC) begin
								r_stream <= 1'b1;
							end else if (w_byte == ads_pkg::CMD_SDATAC) begin
								o_sdatac_seen <= 1'b1;
							end else if ((w_byte[7:5] == ads_pkg::OP_RREG_PREFIX) ||
								(w_byte[7:5] == ads_pkg::OP_WREG_PREFIX)) begin
								r_byte_idx <= 2'd1;  // count byte follows
							end
						end
						2'd1: begin
							r_byte_idx <= 2'd2;
							if ((r_op[7:5] == ads_pkg::OP_RREG_PREFIX) && (r_op[4:0] < 5'd12)) begin
								r_out <= r_regs[r_op[3:0]];  // goes out during the dummy byte
							end
						end
						default: begin
							r_byte_idx <= 2'd0;
							if ((r_op[7:5] == ads_pkg::OP_WREG_PREFIX) && (r_op[4:0] < 5'd12)) begin
								r_regs[r_op[3:0]] <= w_byte;
							end
						end
					endcase
				end
			end

			// conversions only in rdatac with start high
			if (r_stream && i_ads_start) begin
				r_tick <= r_tick + 16'd1;
				if (r_tick == 16'(DRDY_PERIOD - 1)) begin
					r_tick       <= '0;
					o_drdy_n     <= 1'b0;
					r_out        <= w_next_frame[71:64];
					r_frame_sr   <= {w_next_frame[63:0], 8'h00};
					r_frame_left <= 4'd8;
					r_frame_num  <= r_frame_num + 24'd1;
				end else if (r_tick == 16'd4) begin
					o_drdy_n <= 1'b1;  // short low pulse
				end
			end else begin
				r_tick   <= '0;
				o_drdy_n <= 1'b1;
			end
		end
	end

endmodule

// File: test/ads_ctrl_asserts.sv
`timescale 1ns/1ps

// protocol properties on the controller pins
module ads_ctrl_asserts (
	input logic i_CLK,
	input logic i_RSTN,
	input logic i_spi_clk,
	input logic i_spi_csn,
	input logic i_frame_valid,
	input logic i_rreg_valid,
	input logic i_streaming,
	input logic i_ads_start
);

	int fail_cnt = 0;  // failed assertions so far

	// sclk parked while deselected
	sclk_idle: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		i_spi_csn |-> !i_spi_clk)
		else begin
			$error("spi clock high while chip select is high");
			fail_cnt++;
		end

	frame_pulse: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		i_frame_valid |=> !i_frame_valid)
		else begin
			$error("frame valid longer than one cycle");
			fail_cnt++;
		end

	rreg_pulse: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		i_rreg_valid |=> !i_rreg_valid)
		else begin
			$error("read valid longer than one cycle");
			fail_cnt++;
		end

	// start follows the streaming flag
	start_off: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		(!i_streaming && !$past(i_streaming)) |-> !i_ads_start)
		else begin
			$error("start pin high outside streaming");
			fail_cnt++;
		end

endmodule

bind ads1292_ctrl_top ads_ctrl_asserts u_asserts (
	.i_CLK         (i_CLK),
	.i_RSTN        (i_RSTN),
	.i_spi_clk     (o_spi_clk),
	.i_spi_csn     (o_spi_csn),
	.i_frame_valid (o_frame_valid),
	.i_rreg_valid  (o_rreg_valid),
	.i_streaming   (o_streaming),
	.i_ads_start   (o_ads_start)
);

// File: test/tb_ads1292_ctrl.sv
`timescale 1ns/1ps

module tb_ads1292_ctrl;

	localparam int INIT_TIMEOUT  = 1000;  // cycles
	localparam int CMD_TIMEOUT   = 2000;
	localparam int FRAME_TIMEOUT = 1200;  // three drdy periods
	localparam int QUIET_CYCLES  = 1200;

	typedef enum {W_INIT, W_READY, W_RREG, W_FRAME, W_STREAM, W_CSN} watch_e;

	logic               clk = 1'b0;
	logic               rstn;
	ads_pkg::host_cmd_t cmd;
	logic               cmd_valid;
	logic               cmd_ready;
	ads_pkg::byte_t     rreg_data;
	logic               rreg_valid;
	ads_pkg::frame_t    frame;
	logic               frame_valid;
	logic               init_done;
	logic               streaming;
	logic               spi_clk;
	logic               spi_mosi;
	logic               spi_miso;
	logic               spi_csn;
	logic               drdy_n;
	logic               ads_start;
	logic               ads_resetn;
	logic               sdatac_seen;
	logic               saw_resetn_low = 1'b0;
	int                 value_errs = 0;
	int                 timeout_errs = 0;
	int                 other_errs = 0;
	ads_pkg::byte_t     exp_regs [0:11];  // shadow of the model registers
	logic               written [0:11];

	always #20 clk = ~clk;  // 40 ns

	ads1292_ctrl_top #(
		.CLKS_PER_HALF_BIT (2),
		.POR_WAIT_CYCLES   (50),
		.RESET_WAIT_CYCLES (20),
		.CS_HOLD_CYCLES    (8)
	) DUT (
		.i_CLK         (clk),
		.i_RSTN        (rstn),
		.i_cmd         (cmd),
		.i_cmd_valid   (cmd_valid),
		.o_cmd_ready   (cmd_ready),
		.o_rreg_data   (rreg_data),
		.o_rreg_valid  (rreg_valid),
		.o_frame       (frame),
		.o_frame_valid (frame_valid),
		.o_init_done   (init_done),
		.o_streaming   (streaming),
		.i_spi_miso    (spi_miso),
		.i_drdy_n      (drdy_n),
		.o_spi_clk     (spi_clk),
		.o_spi_mosi    (spi_mosi),
		.o_spi_csn     (spi_csn),
		.o_ads_start   (ads_start),
		.o_ads_resetn  (ads_resetn)
	);

	ads1292_model u_model (
		.i_CLK         (clk),
		.i_RSTN        (rstn),
		.i_spi_clk     (spi_clk),
		.i_spi_mosi    (spi_mosi),
		.i_spi_csn     (spi_csn),
		.i_ads_start   (ads_start),
		.i_ads_resetn  (ads_resetn),
		.o_spi_miso    (spi_miso),
		.o_drdy_n      (drdy_n),
		.o_sdatac_seen (sdatac_seen)
	);

	always @(negedge clk) begin
		if (ads_resetn === 1'b0) saw_resetn_low <= 1'b1;  // pulse seen
	end

	// ==============================
	// compare tasks
	// ==============================
	task automatic check_byte(input string name, input ads_pkg::byte_t got,
		input ads_pkg::byte_t exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
			value_errs++;
		end
	endtask

	task automatic check_frame(input string name, input ads_pkg::frame_t got,
		input ads_pkg::frame_t exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
			value_errs++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
			value_errs++;
		end
	endtask

	function automatic logic sample(input watch_e w);
		case (w)
			W_INIT:   return init_done;
			W_READY:  return cmd_ready;
			W_RREG:   return rreg_valid;
			W_FRAME:  return frame_valid;
			W_STREAM: return streaming;
			default:  return spi_csn;
		endcase
	endfunction

	// outputs sampled on the falling edge away from the update
	task automatic wait_until(input watch_e w, input logic level, input int limit,
		input string what);
		int n;
		n = 0;
		@(negedge clk);
		while ((sample(w) !== level) && (n < limit)) begin
			@(negedge clk);
			n++;
		end
		if (sample(w) !== level) begin
			$display("timeout after %0d cycles waiting for %s at t=%0t", limit, what, $time);
			timeout_errs++;
		end
	endtask

	task automatic send_cmd(input ads_pkg::ctrl_e code, input ads_pkg::reg_addr_t addr,
		input ads_pkg::byte_t data);
		wait_until(W_READY, 1'b1, CMD_TIMEOUT, "o_cmd_ready before a command");
		@(posedge clk);
		#1;
		cmd       = '{code: code, addr: addr, data: data};
		cmd_valid = 1'b1;
		wait_until(W_READY, 1'b1, CMD_TIMEOUT, "command handshake");
		@(posedge clk);  // taken on this edge
		#1;
		cmd_valid = 1'b0;
	endtask

	task automatic write_reg(input ads_pkg::reg_addr_t addr, input ads_pkg::byte_t data);
		send_cmd(ads_pkg::CTRL_WREG, addr, data);
		wait_until(W_READY, 1'b1, CMD_TIMEOUT, "o_cmd_ready after WREG");
		exp_regs[addr[3:0]] = data;
		written[addr[3:0]]  = 1'b1;
	endtask

	task automatic read_reg(input ads_pkg::reg_addr_t addr, output ads_pkg::byte_t data);
		send_cmd(ads_pkg::CTRL_RREG, addr, 8'h00);
		wait_until(W_RREG, 1'b1, CMD_TIMEOUT, "o_rreg_valid");
		data = rreg_data;
	endtask

	// ==============================
	// directed tests
	// ==============================
	task automatic power_up_sequence();
		wait_until(W_INIT, 1'b1, INIT_TIMEOUT, "o_init_done");
		check_bit("o_ads_resetn pulsed low", saw_resetn_low, 1'b1);
		check_bit("model got SDATAC", sdatac_seen, 1'b1);
	endtask

	task automatic read_reset_value();
		ads_pkg::byte_t got;
		read_reg(5'd3, got);
		check_byte("o_rreg_data reg 3", got, 8'hA3);
	endtask

	task automatic write_then_read();
		ads_pkg::byte_t got;
		write_reg(5'd5, 8'h5A);
		read_reg(5'd5, got);
		check_byte("o_rreg_data reg 5", got, 8'h5A);
	endtask

	task automatic random_write_read();
		ads_pkg::reg_addr_t addr;
		ads_pkg::byte_t     data;
		ads_pkg::byte_t     got;
		int                 spare;
		for (int i = 0; i < 10; i++) begin
			addr = ads_pkg::reg_addr_t'(1 + ($urandom % 11));  // 1 to 11
			data = ads_pkg::byte_t'($urandom);
			write_reg(addr, data);
			read_reg(addr, got);
			check_byte($sformatf("o_rreg_data reg %0d", addr), got, data);
		end
		spare = 0;  // register 0 sits outside the random range
		for (int i = 11; i >= 1; i--) begin
			if (!written[4'(i)]) spare = i;  // lowest untouched one above 0
		end
		read_reg(ads_pkg::reg_addr_t'(spare), got);
		check_byte($sformatf("o_rreg_data reg %0d", spare), got, 8'hA0 + 8'(spare));
	endtask

	task automatic stream_five_frames();
		logic [23:0]     k;
		ads_pkg::frame_t exp;
		send_cmd(ads_pkg::CTRL_RDATAC, '0, 8'h00);
		wait_until(W_STREAM, 1'b1, CMD_TIMEOUT, "o_streaming to rise");
		check_bit("o_ads_start", ads_start, 1'b1);
		k = '0;
		for (int i = 0; i < 5; i++) begin
			wait_until(W_FRAME, 1'b1, FRAME_TIMEOUT, "o_frame_valid");
			if (i == 0) k = frame[47:24];  // numbering starts wherever the model is
			exp = {24'hC00000, k, ~k};
			check_frame($sformatf("o_frame %0d", i), frame, exp);
			k = k + 24'd1;
		end
	endtask

	task automatic stop_streaming();
		ads_pkg::byte_t got;
		int             extra;
		send_cmd(ads_pkg::CTRL_SDATAC, '0, 8'h00);
		wait_until(W_STREAM, 1'b0, CMD_TIMEOUT, "o_streaming to fall");
		wait_until(W_CSN, 1'b1, CMD_TIMEOUT, "o_spi_csn to rise");
		check_bit("o_ads_start", ads_start, 1'b0);
		extra = 0;
		repeat (QUIET_CYCLES) begin
			@(negedge clk);
			if (frame_valid) extra++;
		end
		if (extra != 0) begin
			$display("%0d frames delivered after the stop command", extra);
			other_errs++;
		end
		read_reg(5'd3, got);
		check_byte("o_rreg_data reg 3 after stop", got, exp_regs[3]);
	endtask

	// ==============================
	// main sequence
	// ==============================
	initial begin
		void'($urandom(36));
		rstn      = 1'b0;
		cmd       = '0;
		cmd_valid = 1'b0;
		for (int i = 0; i < 12; i++) begin
			exp_regs[4'(i)] = 8'hA0 + 8'(i);
			written[4'(i)]  = 1'b0;
		end
		repeat (8) @(posedge clk);
		#1;
		rstn = 1'b1;

		power_up_sequence();
		read_reset_value();
		write_then_read();
		random_write_read();
		stream_five_frames();
		stop_streaming();

		$display("errors: %0d value, %0d timeout, %0d other, %0d assertion",
			value_errs, timeout_errs, other_errs, DUT.u_asserts.fail_cnt);
		if ((value_errs + timeout_errs + other_errs + DUT.u_asserts.fail_cnt) == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// hard stop after about 50k cycles
	initial begin
		#2_000_000;
		$display("run stuck, stopped by the watchdog at t=%0t", $time);
		$display("errors: %0d value, %0d timeout, %0d other, %0d assertion",
			value_errs, timeout_errs, other_errs, DUT.u_asserts.fail_cnt);
		$display("Something failed");
		$finish;
	end

endmodule

// File: project.f
logic/ads_pkg.sv
logic/spi_byte_master.sv
logic/frame_reader.sv
logic/ads_sequencer.sv
logic/ads1292_ctrl_top.sv
test/ads1292_model.sv
test/ads_ctrl_asserts.sv
test/tb_ads1292_ctrl.sv

// File: run.sh
#!/bin/sh
# build and run the testbench, verdict from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_ads1292_ctrl -f project.f \
	&& ./obj_dir/Vtb_ads1292_ctrl +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Everything OK" sim.log 2>/dev/null && echo "simulation passed" && exit 0 \
	|| { echo "simulation failed"; exit 1; }
